//--- otter_csr.f
+incdir+common
common/csr_pkg.sv
hdl/csr_field_reg.sv
hdl/csr_read_mux.sv
csr_ctrl/csr_intr_arbiter.sv
csr_ctrl/csr_trap_ctrl.sv
hdl/otter_csr.sv
sim/otter_csr_assertions.sv
sim/otter_csr_tb.sv

//--- sim/otter_csr_tb.sv
`include "csr_cfg.svh"

module otter_csr_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import csr_pkg::*;

    // Operations after reset set the cycle limit
    localparam int NUM_OPS        = 152;
    localparam int TIMEOUT_CYCLES = 40 + 4 * NUM_OPS;

    localparam csr_addr_t RW_ADDR [`CSR_NUM_RW] = '{
        `CSR_ADDR_MSTATUS, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC, `CSR_ADDR_MSCRATCH,
        `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL, `CSR_ADDR_MIP
    };
    localparam csr_addr_t ID_ADDR [5] = '{
        `CSR_ADDR_MISA, `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID,
        `CSR_ADDR_MIMPID, `CSR_ADDR_MHARTID
    };
    // Bit 1 of the third set is outside the mip mask
    localparam intrpt_vec_t INTR_LINES [5] = '{
        32'h0000_0888, 32'h0000_0088, 32'h0001_080A, 32'h8001_0008, 32'h0000_0800
    };

    logic        i_clk = 1'b0;
    logic        i_rst;
    logic        i_mask_intrpt;
    intrpt_vec_t i_intrpt;
    excp_sel_t   i_excp;
    logic        i_csr_we;
    csr_op_t     i_csr_op_sel;
    csr_rx_t     i_csr_rx_sel;
    csr_addr_t   i_csr_addr;
    csr_data_t   i_csr_w_data;
    csr_data_t   i_trap_pc;
    csr_data_t   i_trap_mtval;
    csr_data_t   o_csr_r_data;
    csr_data_t   o_epc_addr;
    logic        o_excp;
    logic        o_trap;

    // Reference state and expected outputs of the current cycle
    csr_data_t shadow [`CSR_NUM_RW] = '{default: '0};
    string     exp_name;
    csr_data_t exp_rdata;
    csr_data_t exp_epc;
    logic      exp_trap;
    logic      exp_excp;
    logic      chk_en = 1'b0;
    int        seed = 64;
    int        cycle_count = 0;

    otter_csr otter_csr_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_mask_intrpt (i_mask_intrpt),
        .i_intrpt      (i_intrpt),
        .i_excp        (i_excp),
        .i_csr_we      (i_csr_we),
        .i_csr_op_sel  (i_csr_op_sel),
        .i_csr_rx_sel  (i_csr_rx_sel),
        .i_csr_addr    (i_csr_addr),
        .i_csr_w_data  (i_csr_w_data),
        .i_trap_pc     (i_trap_pc),
        .i_trap_mtval  (i_trap_mtval),
        .o_csr_r_data  (o_csr_r_data),
        .o_epc_addr    (o_epc_addr),
        .o_excp        (o_excp),
        .o_trap        (o_trap)
    );

    always #10 i_clk = ~i_clk;

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic int idx_of(input csr_addr_t addr);
        for (int i = 0; i < `CSR_NUM_RW; i++) begin
            if (RW_ADDR[i] == addr) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic csr_data_t mask_of(input int idx);
        case (idx)
            `CSR_IDX_MSTATUS:  return `CSR_MSTATUS_MASK;
            `CSR_IDX_MIE:      return `CSR_MIE_MASK;
            `CSR_IDX_MTVEC:    return `CSR_MTVEC_MASK;
            `CSR_IDX_MSCRATCH: return `CSR_MSCRATCH_MASK;
            `CSR_IDX_MEPC:     return `CSR_MEPC_MASK;
            `CSR_IDX_MCAUSE:   return `CSR_MCAUSE_MASK;
            `CSR_IDX_MTVAL:    return `CSR_MTVAL_MASK;
            default:           return `CSR_MIP_MASK;
        endcase
    endfunction

    function automatic csr_data_t read_value_of(input csr_addr_t addr);
        int idx;
        idx = idx_of(addr);
        if (idx >= 0) begin
            return shadow[idx];
        end
        case (addr)
            `CSR_ADDR_MISA:      return `CSR_MISA_VALUE;
            `CSR_ADDR_MVENDORID: return `CSR_MVENDORID_VALUE;
            `CSR_ADDR_MARCHID:   return `CSR_MARCHID_VALUE;
            `CSR_ADDR_MIMPID:    return `CSR_MIMPID_VALUE;
            `CSR_ADDR_MHARTID:   return `CSR_MHARTID_VALUE;
            default:             return '0;
        endcase
    endfunction

    // RW, RS or RC result merged under the slice mask
    function automatic csr_data_t write_result(input int idx, input csr_rx_t rx,
            input csr_data_t wd);
        csr_data_t old;
        csr_data_t res;
        old = shadow[idx];
        case (rx)
            `CSR_RX_RW: res = wd;
            `CSR_RX_RS: res = old | wd;
            `CSR_RX_RC: res = old & ~wd;
            default:    res = old;
        endcase
        return (res & mask_of(idx)) | (old & ~mask_of(idx));
    endfunction

    function automatic csr_data_t exception_cause(input excp_sel_t excp);
        case (excp)
            4'd1:    return 32'd2;
            4'd2:    return 32'd0;
            4'd3:    return 32'd6;
            default: return 32'd4;
        endcase
    endfunction

    function automatic intrpt_code_t highest_intr_code(input csr_data_t pend);
        for (int i = 31; i >= 16; i--) begin
            if (pend[i]) begin
                return intrpt_code_t'(i);
            end
        end
        if (pend[11]) return 5'd11;
        if (pend[7]) return 5'd7;
        return 5'd3;
    endfunction

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    task automatic fail_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input csr_data_t exp, input csr_data_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            fail_run();
        end
    endtask

    // Sampled 2 ns before the next rising edge
    always begin
        @(posedge i_clk);
        #18;
        if (chk_en) begin
            check_data({exp_name, " read data"}, exp_rdata, o_csr_r_data);
            check_data({exp_name, " redirect"}, exp_epc, o_epc_addr);
            check_flag({exp_name, " trap"}, exp_trap, o_trap);
            check_flag({exp_name, " interrupt"}, exp_excp, o_excp);
        end
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    task automatic run_cycle(input string name, input logic mask, input intrpt_vec_t lines,
            input excp_sel_t excp, input csr_op_t op, input csr_rx_t rx,
            input csr_addr_t addr, input csr_data_t wd);
        csr_data_t    pend;
        csr_data_t    base;
        csr_data_t    cause;
        csr_data_t    nxt [`CSR_NUM_RW];
        logic         take;
        logic         entry;
        intrpt_code_t code;
        @(posedge i_clk);
        #2;
        i_mask_intrpt = mask;
        i_intrpt      = lines;
        i_excp        = excp;
        i_csr_we      = (op == `CSR_OP_WRITE);
        i_csr_op_sel  = op;
        i_csr_rx_sel  = rx;
        i_csr_addr    = addr;
        i_csr_w_data  = wd;
        i_trap_pc     = $random(seed);
        i_trap_mtval  = $random(seed);
        pend  = shadow[`CSR_IDX_MIE] & shadow[`CSR_IDX_MIP];
        code  = highest_intr_code(pend);
        take  = shadow[`CSR_IDX_MSTATUS][3] && (pend != '0) && !mask;
        base  = shadow[`CSR_IDX_MTVEC] & 32'hFFFF_FFFC;
        nxt   = shadow;
        entry = 1'b0;
        cause = '0;
        exp_name  = name;
        exp_rdata = read_value_of(addr);
        exp_epc   = base;
        exp_trap  = 1'b0;
        exp_excp  = take;
        nxt[`CSR_IDX_MIP] = shadow[`CSR_IDX_MIP] | (lines & `CSR_MIP_MASK);
        if (take) begin
            entry = 1'b1;
            cause = {1'b1, 26'd0, code};
            nxt[`CSR_IDX_MIP] = '0;
            if (shadow[`CSR_IDX_MTVEC][0]) begin
                exp_epc = base + 32'(code) * 4;
            end
        end else if (excp != '0) begin
            entry    = 1'b1;
            exp_trap = 1'b1;
            cause    = exception_cause(excp);
            nxt[`CSR_IDX_MTVAL] = i_trap_mtval;
        end else if (op == `CSR_OP_ECALL) begin
            entry    = 1'b1;
            exp_trap = 1'b1;
            cause    = 32'd11;
        end else if (op == `CSR_OP_EBREAK) begin
            entry    = 1'b1;
            exp_trap = 1'b1;
            cause    = 32'd3;
            nxt[`CSR_IDX_MTVAL] = i_trap_mtval;
        end else if (op == `CSR_OP_MRET) begin
            exp_trap = 1'b1;
            exp_epc  = shadow[`CSR_IDX_MEPC];
            nxt[`CSR_IDX_MSTATUS][3] = shadow[`CSR_IDX_MSTATUS][7];
            nxt[`CSR_IDX_MSTATUS][7] = 1'b1;
        end else if (op == `CSR_OP_WRITE && idx_of(addr) >= 0) begin
            nxt[idx_of(addr)] = write_result(idx_of(addr), rx, wd);
        end
        if (entry) begin
            nxt[`CSR_IDX_MSTATUS][7] = shadow[`CSR_IDX_MSTATUS][3];
            nxt[`CSR_IDX_MSTATUS][3] = 1'b0;
            nxt[`CSR_IDX_MEPC]       = i_trap_pc;
            nxt[`CSR_IDX_MCAUSE]     = cause;
        end
        shadow = nxt;
        chk_en = 1'b1;
    endtask

    task automatic read_csr(input string name, input csr_addr_t addr);
        run_cycle(name, 1'b1, '0, '0, `CSR_OP_NONE, '0, addr, '0);
    endtask

    task automatic write_csr(input string name, input csr_addr_t addr, input csr_rx_t rx,
            input csr_data_t wd);
        run_cycle(name, 1'b1, '0, '0, `CSR_OP_WRITE, rx, addr, wd);
    endtask

    initial begin
        i_rst         = 1'b1;
        i_mask_intrpt = 1'b1;
        i_intrpt      = '0;
        // An exception held through reset must not trap
        i_excp        = `CSR_EXCP_ILLEGAL_INSTR;
        i_csr_we      = 1'b0;
        i_csr_op_sel  = `CSR_OP_NONE;
        i_csr_rx_sel  = '0;
        i_csr_addr    = '0;
        i_csr_w_data  = '0;
        i_trap_pc     = '0;
        i_trap_mtval  = '0;
        repeat (16) @(posedge i_clk);
        #2;
        i_rst  = 1'b0;
        i_excp = '0;

        // Reset values
        for (int i = 0; i < `CSR_NUM_RW; i++) read_csr("reset_rw", RW_ADDR[i]);
        for (int i = 0; i < 5; i++) read_csr("reset_identity", ID_ADDR[i]);

        // Software writes with random data
        for (int i = 0; i < `CSR_NUM_RW; i++) begin
            for (int f = 1; f <= 3; f++) begin
                write_csr("sw_write", RW_ADDR[i], csr_rx_t'(f), $random(seed));
                read_csr("sw_readback", RW_ADDR[i]);
            end
        end
        for (int i = 0; i < 5; i++) begin
            write_csr("identity_write", ID_ADDR[i], `CSR_RX_RW, $random(seed));
            read_csr("identity_readback", ID_ADDR[i]);
        end

        // Exceptions 1 to 4 followed by ecall and ebreak
        for (int e = 1; e <= 6; e++) begin
            write_csr("trap_setup", `CSR_ADDR_MSTATUS, `CSR_RX_RW, 32'h8);
            if (e <= 4) begin
                run_cycle("exception", 1'b1, '0, excp_sel_t'(e), `CSR_OP_NONE, '0,
                          `CSR_ADDR_MTVEC, '0);
            end else begin
                run_cycle("ecall_ebreak", 1'b1, '0, '0,
                          (e == 5) ? `CSR_OP_ECALL : `CSR_OP_EBREAK, '0, `CSR_ADDR_MTVEC, '0);
            end
            read_csr("trap_mepc", `CSR_ADDR_MEPC);
            read_csr("trap_mcause", `CSR_ADDR_MCAUSE);
            read_csr("trap_mtval", `CSR_ADDR_MTVAL);
            read_csr("trap_mstatus", `CSR_ADDR_MSTATUS);
        end

        // mret with the saved enable set and clear
        for (int k = 0; k < 2; k++) begin
            write_csr("mret_setup", `CSR_ADDR_MSTATUS, `CSR_RX_RW, (k == 0) ? 32'h80 : 32'h0);
            run_cycle("mret", 1'b1, '0, '0, `CSR_OP_MRET, '0, `CSR_ADDR_MEPC, '0);
            read_csr("mret_mstatus", `CSR_ADDR_MSTATUS);
        end

        // ------------------------------------------------------------
        // Interrupts in vectored mode first and then direct
        // ------------------------------------------------------------
        write_csr("intr_setup", `CSR_ADDR_MIP, `CSR_RX_RW, '0);
        write_csr("intr_setup", `CSR_ADDR_MIE, `CSR_RX_RW, `CSR_MIE_MASK);
        write_csr("intr_setup", `CSR_ADDR_MTVEC, `CSR_RX_RW, 32'h0000_2001);
        for (int k = 0; k < 5; k++) begin
            if (k == 4) write_csr("intr_direct", `CSR_ADDR_MTVEC, `CSR_RX_RW, 32'h0000_3000);
            write_csr("intr_enable", `CSR_ADDR_MSTATUS, `CSR_RX_RW, 32'h8);
            run_cycle("intr_raise", 1'b1, INTR_LINES[k], '0, `CSR_OP_NONE, '0, `CSR_ADDR_MIP, '0);
            run_cycle("intr_take", 1'b0, '0, '0, `CSR_OP_NONE, '0, `CSR_ADDR_MIP, '0);
            read_csr("intr_mcause", `CSR_ADDR_MCAUSE);
            read_csr("intr_mip", `CSR_ADDR_MIP);
            read_csr("intr_mstatus", `CSR_ADDR_MSTATUS);
        end

        // Masked interrupt loses to an exception
        write_csr("mask_enable", `CSR_ADDR_MSTATUS, `CSR_RX_RW, 32'h8);
        run_cycle("mask_raise", 1'b1, 32'h80, '0, `CSR_OP_NONE, '0, `CSR_ADDR_MIP, '0);
        run_cycle("mask_exception", 1'b1, '0, 4'd1, `CSR_OP_NONE, '0, `CSR_ADDR_MCAUSE, '0);
        read_csr("mask_mcause", `CSR_ADDR_MCAUSE);
        read_csr("mask_mip", `CSR_ADDR_MIP);

        @(posedge i_clk);
        chk_en = 1'b0;
        $display("All checks passed");
        $finish;
    end

endmodule

//--- sim/otter_csr_assertions.sv
`include "csr_cfg.svh"

module otter_csr_assertions (
    input logic               i_clk,
    input logic               i_rst,
    input logic               i_trap,
    input logic               i_excp,
    input csr_pkg::csr_data_t i_mstatus
);
    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------------------------------------
    // Trap outputs
    // ------------------------------------------------------------
    trap_excp_exclusive: assert property (@(posedge i_clk) !(i_trap && i_excp))
        else $error("o_trap and o_excp were high in the same cycle");

    quiet_in_reset: assert property (@(posedge i_clk) i_rst |-> (!i_trap && !i_excp))
        else $error("o_trap or o_excp was high during reset");

    // Global enable drops once an interrupt is taken
    mie_cleared_after_intr: assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_excp |=> !i_mstatus[`CSR_MSTATUS_MIE_BIT]
    ) else $error("mstatus global enable still set after an interrupt");

endmodule

bind otter_csr otter_csr_assertions otter_csr_assertions_i (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_trap    (o_trap),
    .i_excp    (o_excp),
    .i_mstatus (reg_value[`CSR_IDX_MSTATUS])
);

//--- hdl/otter_csr.sv
`include "csr_cfg.svh"

module otter_csr (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_mask_intrpt,
    input  csr_pkg::intrpt_vec_t i_intrpt,
    input  csr_pkg::excp_sel_t   i_excp,
    input  logic                 i_csr_we,
    input  csr_pkg::csr_op_t     i_csr_op_sel,
    input  csr_pkg::csr_rx_t     i_csr_rx_sel,
    input  csr_pkg::csr_addr_t   i_csr_addr,
    input  csr_pkg::csr_data_t   i_csr_w_data,
    input  csr_pkg::csr_data_t   i_trap_pc,
    input  csr_pkg::csr_data_t   i_trap_mtval,
    output csr_pkg::csr_data_t   o_csr_r_data,
    output csr_pkg::csr_data_t   o_epc_addr,
    output logic                 o_excp,
    output logic                 o_trap
);
    import csr_pkg::*;

    // Per-slice software write masks
    localparam csr_data_t RW_MASK [`CSR_NUM_RW] = '{
        `CSR_IDX_MSTATUS:  `CSR_MSTATUS_MASK,
        `CSR_IDX_MIE:      `CSR_MIE_MASK,
        `CSR_IDX_MTVEC:    `CSR_MTVEC_MASK,
        `CSR_IDX_MSCRATCH: `CSR_MSCRATCH_MASK,
        `CSR_IDX_MEPC:     `CSR_MEPC_MASK,
        `CSR_IDX_MCAUSE:   `CSR_MCAUSE_MASK,
        `CSR_IDX_MTVAL:    `CSR_MTVAL_MASK,
        `CSR_IDX_MIP:      `CSR_MIP_MASK
    };

    logic [`CSR_NUM_RW-1:0] reg_we;
    logic [`CSR_NUM_RW-1:0] reg_sw;
    csr_data_t              reg_data  [`CSR_NUM_RW];
    csr_data_t              reg_value [`CSR_NUM_RW];
    logic                   intrpt_valid;
    intrpt_code_t           intrpt_code;

    // ------------------------------------------------------------
    // Interrupt selection
    // ------------------------------------------------------------
    csr_intr_arbiter csr_intr_arbiter_i (
        .i_mstatus (reg_value[`CSR_IDX_MSTATUS]),
        .i_mie     (reg_value[`CSR_IDX_MIE]),
        .i_mip     (reg_value[`CSR_IDX_MIP]),
        .o_valid   (intrpt_valid),
        .o_code    (intrpt_code)
    );

    csr_trap_ctrl csr_trap_ctrl_i (
        .i_rst          (i_rst),
        .i_mask_intrpt  (i_mask_intrpt),
        .i_intrpt       (i_intrpt),
        .i_excp         (i_excp),
        .i_csr_we       (i_csr_we),
        .i_csr_op_sel   (i_csr_op_sel),
        .i_csr_rx_sel   (i_csr_rx_sel),
        .i_csr_addr     (i_csr_addr),
        .i_csr_w_data   (i_csr_w_data),
        .i_csr_r_data   (o_csr_r_data),
        .i_trap_pc      (i_trap_pc),
        .i_trap_mtval   (i_trap_mtval),
        .i_mstatus      (reg_value[`CSR_IDX_MSTATUS]),
        .i_mtvec        (reg_value[`CSR_IDX_MTVEC]),
        .i_mepc         (reg_value[`CSR_IDX_MEPC]),
        .i_mip          (reg_value[`CSR_IDX_MIP]),
        .i_intrpt_valid (intrpt_valid),
        .i_intrpt_code  (intrpt_code),
        .o_reg_we       (reg_we),
        .o_reg_sw       (reg_sw),
        .o_reg_data     (reg_data),
        .o_epc_addr     (o_epc_addr),
        .o_excp         (o_excp),
        .o_trap         (o_trap)
    );

    // ------------------------------------------------------------
    // Writable register slices
    // ------------------------------------------------------------
    for (genvar g = 0; g < `CSR_NUM_RW; g++) begin : g_rw_reg
        csr_field_reg #(
            .WRITE_MASK (RW_MASK[g])
        ) csr_field_reg_i (
            .i_clk   (i_clk),
            .i_rst   (i_rst),
            .i_we    (reg_we[g]),
            .i_sw    (reg_sw[g]),
            .i_data  (reg_data[g]),
            .o_value (reg_value[g])
        );
    end

    csr_read_mux csr_read_mux_i (
        .i_csr_addr   (i_csr_addr),
        .i_reg_value  (reg_value),
        .o_csr_r_data (o_csr_r_data)
    );

endmodule

//--- csr_ctrl/csr_trap_ctrl.sv
`include "csr_cfg.svh"

module csr_trap_ctrl (
    input  logic                   i_rst,
    input  logic                   i_mask_intrpt,
    input  csr_pkg::intrpt_vec_t   i_intrpt,
    input  csr_pkg::excp_sel_t     i_excp,
    input  logic                   i_csr_we,
    input  csr_pkg::csr_op_t       i_csr_op_sel,
    input  csr_pkg::csr_rx_t       i_csr_rx_sel,
    input  csr_pkg::csr_addr_t     i_csr_addr,
    input  csr_pkg::csr_data_t     i_csr_w_data,
    input  csr_pkg::csr_data_t     i_csr_r_data,
    input  csr_pkg::csr_data_t     i_trap_pc,
    input  csr_pkg::csr_data_t     i_trap_mtval,
    input  csr_pkg::csr_data_t     i_mstatus,
    input  csr_pkg::csr_data_t     i_mtvec,
    input  csr_pkg::csr_data_t     i_mepc,
    input  csr_pkg::csr_data_t     i_mip,
    input  logic                   i_intrpt_valid,
    input  csr_pkg::intrpt_code_t  i_intrpt_code,
    output logic [`CSR_NUM_RW-1:0] o_reg_we,
    output logic [`CSR_NUM_RW-1:0] o_reg_sw,
    output csr_pkg::csr_data_t     o_reg_data [`CSR_NUM_RW],
    output csr_pkg::csr_data_t     o_epc_addr,
    output logic                   o_excp,
    output logic                   o_trap
);
    import csr_pkg::*;

    logic      take_intrpt;
    logic      entry;
    logic      save_mtval;
    logic      mret;
    logic      sw_write;
    logic      sw_hit;
    csr_idx_t  sw_idx;
    csr_data_t cause;
    csr_data_t excp_cause;
    csr_data_t sw_result;
    csr_data_t entry_mstatus;
    csr_data_t ret_mstatus;
    csr_data_t vec_base;

    assign take_intrpt = !i_rst && i_intrpt_valid && !i_mask_intrpt;
    assign vec_base    = i_mtvec & `CSR_EPC_BASE_MASK;

    // ------------------------------------------------------------
    // Event priority from interrupt to exception to operation
    // ------------------------------------------------------------
    always_comb begin
        entry      = 1'b0;
        save_mtval = 1'b0;
        mret       = 1'b0;
        sw_write   = 1'b0;
        cause      = '0;
        if (i_rst) begin
            cause = '0;
        end else if (take_intrpt) begin
            entry = 1'b1;
            cause = csr_data_t'(i_intrpt_code) | (csr_data_t'(1) << `CSR_MCAUSE_INTRPT_BIT);
        end else if (|i_excp) begin
            entry      = 1'b1;
            save_mtval = 1'b1;
            cause      = excp_cause;
        end else begin
            case (i_csr_op_sel)
                `CSR_OP_WRITE:  sw_write = i_csr_we;
                `CSR_OP_ECALL: begin
                    entry = 1'b1;
                    cause = `CSR_CAUSE_ECALL;
                end
                `CSR_OP_EBREAK: begin
                    entry      = 1'b1;
                    save_mtval = 1'b1;
                    cause      = `CSR_CAUSE_EBREAK;
                end
                `CSR_OP_MRET:   mret = 1'b1;
                default:        ;
            endcase
        end
    end

    always_comb begin
        case (i_excp)
            `CSR_EXCP_ILLEGAL_INSTR:  excp_cause = `CSR_CAUSE_ILLEGAL_INSTR;
            `CSR_EXCP_INSTR_MISALIGN: excp_cause = `CSR_CAUSE_INSTR_MISALIGN;
            `CSR_EXCP_STORE_MISALIGN: excp_cause = `CSR_CAUSE_STORE_MISALIGN;
            `CSR_EXCP_LOAD_MISALIGN:  excp_cause = `CSR_CAUSE_LOAD_MISALIGN;
            default:                  excp_cause = '0;
        endcase
    end

    // Software write result and target slice
    always_comb begin
        case (i_csr_rx_sel)
            `CSR_RX_RW: sw_result = i_csr_w_data;
            `CSR_RX_RS: sw_result = i_csr_r_data | i_csr_w_data;
            `CSR_RX_RC: sw_result = i_csr_r_data & ~i_csr_w_data;
            default:    sw_result = i_csr_r_data;
        endcase
        sw_hit = 1'b1;
        case (i_csr_addr)
            `CSR_ADDR_MSTATUS:  sw_idx = `CSR_IDX_MSTATUS;
            `CSR_ADDR_MIE:      sw_idx = `CSR_IDX_MIE;
            `CSR_ADDR_MTVEC:    sw_idx = `CSR_IDX_MTVEC;
            `CSR_ADDR_MSCRATCH: sw_idx = `CSR_IDX_MSCRATCH;
            `CSR_ADDR_MEPC:     sw_idx = `CSR_IDX_MEPC;
            `CSR_ADDR_MCAUSE:   sw_idx = `CSR_IDX_MCAUSE;
            `CSR_ADDR_MTVAL:    sw_idx = `CSR_IDX_MTVAL;
            `CSR_ADDR_MIP:      sw_idx = `CSR_IDX_MIP;
            default: begin
                // Identity and unknown addresses are not writable
                sw_idx = '0;
                sw_hit = 1'b0;
            end
        endcase
    end

    always_comb begin
        entry_mstatus = i_mstatus;
        entry_mstatus[`CSR_MSTATUS_MPIE_BIT] = i_mstatus[`CSR_MSTATUS_MIE_BIT];
        entry_mstatus[`CSR_MSTATUS_MIE_BIT]  = 1'b0;
        ret_mstatus = i_mstatus;
        ret_mstatus[`CSR_MSTATUS_MIE_BIT]  = i_mstatus[`CSR_MSTATUS_MPIE_BIT];
        ret_mstatus[`CSR_MSTATUS_MPIE_BIT] = 1'b1;
    end

    // ------------------------------------------------------------
    // Slice strobes and data
    // ------------------------------------------------------------
    always_comb begin
        o_reg_we   = '0;
        o_reg_sw   = '0;
        o_reg_data = '{default: '0};
        if (!i_rst) begin
            // Latch newly raised lines into mip
            o_reg_we[`CSR_IDX_MIP]   = 1'b1;
            o_reg_data[`CSR_IDX_MIP] = i_mip | (i_intrpt & `CSR_MIP_MASK);
        end
        if (entry) begin
            o_reg_we[`CSR_IDX_MSTATUS]   = 1'b1;
            o_reg_data[`CSR_IDX_MSTATUS] = entry_mstatus;
            o_reg_we[`CSR_IDX_MEPC]      = 1'b1;
            o_reg_data[`CSR_IDX_MEPC]    = i_trap_pc;
            o_reg_we[`CSR_IDX_MCAUSE]    = 1'b1;
            o_reg_data[`CSR_IDX_MCAUSE]  = cause;
        end
        if (save_mtval) begin
            o_reg_we[`CSR_IDX_MTVAL]   = 1'b1;
            o_reg_data[`CSR_IDX_MTVAL] = i_trap_mtval;
        end
        if (take_intrpt) begin
            o_reg_data[`CSR_IDX_MIP] = '0;
        end
        if (mret) begin
            o_reg_we[`CSR_IDX_MSTATUS]   = 1'b1;
            o_reg_data[`CSR_IDX_MSTATUS] = ret_mstatus;
        end
        if (sw_write && sw_hit) begin
            o_reg_we[sw_idx]   = 1'b1;
            o_reg_sw[sw_idx]   = 1'b1;
            o_reg_data[sw_idx] = sw_result;
        end
    end

    // Redirect target for the fetch stage
    always_comb begin
        if (take_intrpt && i_mtvec[`CSR_MTVEC_MODE_BIT]) begin
            o_epc_addr = vec_base + (csr_data_t'(i_intrpt_code) << 2);
        end else if (mret) begin
            o_epc_addr = i_mepc;
        end else begin
            o_epc_addr = vec_base;
        end
    end

    assign o_excp = take_intrpt;
    assign o_trap = (entry && !take_intrpt) || mret;

endmodule

//--- csr_ctrl/csr_intr_arbiter.sv
`include "csr_cfg.svh"

module csr_intr_arbiter (
    input  csr_pkg::csr_data_t    i_mstatus,
    input  csr_pkg::csr_data_t    i_mie,
    input  csr_pkg::csr_data_t    i_mip,
    output logic                  o_valid,
    output csr_pkg::intrpt_code_t o_code
);
    import csr_pkg::*;

    // Enabled and pending
    csr_data_t pend;

    assign pend = i_mie & i_mip;

    // Global enable gates everything
    assign o_valid = i_mstatus[`CSR_MSTATUS_MIE_BIT] && (|pend);

    // ------------------------------------------------------------
    // Fixed priority from 31 down to 16 and then 11, 7 and 3
    // Later assignments win, so lowest priority goes first
    // ------------------------------------------------------------
    always_comb begin
        o_code = '0;
        if (pend[3]) begin
            o_code = intrpt_code_t'(3);
        end
        if (pend[7]) begin
            o_code = intrpt_code_t'(7);
        end
        if (pend[11]) begin
            o_code = intrpt_code_t'(11);
        end
        // Platform lines
        for (int i = 16; i < 32; i++) begin
            if (pend[i]) begin
                o_code = intrpt_code_t'(i);
            end
        end
    end

endmodule

//--- hdl/csr_read_mux.sv
`include "csr_cfg.svh"

module csr_read_mux (
    input  csr_pkg::csr_addr_t i_csr_addr,
    input  csr_pkg::csr_data_t i_reg_value [`CSR_NUM_RW],
    output csr_pkg::csr_data_t o_csr_r_data
);

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------
    always_comb begin
        // Unknown addresses read zero
        o_csr_r_data = '0;
        case (i_csr_addr)
            // Writable slices
            `CSR_ADDR_MSTATUS:  o_csr_r_data = i_reg_value[`CSR_IDX_MSTATUS];
            `CSR_ADDR_MIE:      o_csr_r_data = i_reg_value[`CSR_IDX_MIE];
            `CSR_ADDR_MTVEC:    o_csr_r_data = i_reg_value[`CSR_IDX_MTVEC];
            `CSR_ADDR_MSCRATCH: o_csr_r_data = i_reg_value[`CSR_IDX_MSCRATCH];
            `CSR_ADDR_MEPC:     o_csr_r_data = i_reg_value[`CSR_IDX_MEPC];
            `CSR_ADDR_MCAUSE:   o_csr_r_data = i_reg_value[`CSR_IDX_MCAUSE];
            `CSR_ADDR_MTVAL:    o_csr_r_data = i_reg_value[`CSR_IDX_MTVAL];
            `CSR_ADDR_MIP:      o_csr_r_data = i_reg_value[`CSR_IDX_MIP];

            // Identity constants
            `CSR_ADDR_MISA:      o_csr_r_data = `CSR_MISA_VALUE;
            `CSR_ADDR_MVENDORID: o_csr_r_data = `CSR_MVENDORID_VALUE;
            `CSR_ADDR_MARCHID:   o_csr_r_data = `CSR_MARCHID_VALUE;
            `CSR_ADDR_MIMPID:    o_csr_r_data = `CSR_MIMPID_VALUE;
            `CSR_ADDR_MHARTID:   o_csr_r_data = `CSR_MHARTID_VALUE;

            default:            ;
        endcase
    end

endmodule

//--- hdl/csr_field_reg.sv
module csr_field_reg #(
    parameter csr_pkg::csr_data_t WRITE_MASK = 32'hFFFF_FFFF
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_we,
    input  logic               i_sw,
    input  csr_pkg::csr_data_t i_data,
    output csr_pkg::csr_data_t o_value
);
    import csr_pkg::*;

    // Software merge keeps the bits outside the mask
    csr_data_t merged;
    csr_data_t next_value;

    assign merged = (i_data & WRITE_MASK) | (o_value & ~WRITE_MASK);

    // Hardware updates take the value whole
    assign next_value = i_sw ? merged : i_data;

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_value <= '0;
        end else if (i_we) begin
            o_value <= next_value;
        end
    end

endmodule

//--- common/csr_pkg.sv
package csr_pkg;

    // ------------------------------------------------------------
    // Register and bus widths
    // ------------------------------------------------------------

    // One CSR value
    typedef logic [31:0] csr_data_t;

    // CSR address from the instruction
    typedef logic [11:0] csr_addr_t;

    // ------------------------------------------------------------
    // Decode selects
    // ------------------------------------------------------------
    typedef logic [2:0] csr_op_t;
    typedef logic [1:0] csr_rx_t;

    // Zero means no exception
    typedef logic [3:0] excp_sel_t;

    // ------------------------------------------------------------
    // Interrupts and slice indexing
    // ------------------------------------------------------------
    typedef logic [31:0] intrpt_vec_t;
    typedef logic [4:0]  intrpt_code_t;

    // Index of a writable register slice
    typedef logic [2:0] csr_idx_t;

endpackage

//--- common/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// ------------------------------------------------------------
// Writable CSR slices
// ------------------------------------------------------------
`define CSR_NUM_RW          8
`define CSR_IDX_MSTATUS     3'd0
`define CSR_IDX_MIE         3'd1
`define CSR_IDX_MTVEC       3'd2
`define CSR_IDX_MSCRATCH    3'd3
`define CSR_IDX_MEPC        3'd4
`define CSR_IDX_MCAUSE      3'd5
`define CSR_IDX_MTVAL       3'd6
`define CSR_IDX_MIP         3'd7

// ------------------------------------------------------------
// Addresses
// ------------------------------------------------------------
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MIP        12'h344
`define CSR_ADDR_MVENDORID  12'hF11
`define CSR_ADDR_MARCHID    12'hF12
`define CSR_ADDR_MIMPID     12'hF13
`define CSR_ADDR_MHARTID    12'hF14

// Software write masks
`define CSR_MSTATUS_MASK    32'h0000_0088
`define CSR_MIE_MASK        32'hFFFF_0888
`define CSR_MIP_MASK        32'hFFFF_0888
// Mode lives in mtvec bit 0
// Bit 1 is reserved and reads 0
`define CSR_MTVEC_MASK      32'hFFFF_FFFD
`define CSR_MSCRATCH_MASK   32'hFFFF_FFFF
`define CSR_MEPC_MASK       32'hFFFF_FFFC
`define CSR_MCAUSE_MASK     32'hFFFF_FFFF
`define CSR_MTVAL_MASK      32'hFFFF_FFFF

// Bit positions and trap base alignment
`define CSR_MSTATUS_MIE_BIT  3
`define CSR_MSTATUS_MPIE_BIT 7
`define CSR_MTVEC_MODE_BIT   0
`define CSR_MCAUSE_INTRPT_BIT 31
`define CSR_EPC_BASE_MASK    32'hFFFF_FFFC

// Identity values with misa for RV32I
`define CSR_MISA_VALUE      32'h4000_0100
`define CSR_MVENDORID_VALUE 32'h0000_0000
`define CSR_MARCHID_VALUE   32'h0000_0000
`define CSR_MIMPID_VALUE    32'h0000_0001
`define CSR_MHARTID_VALUE   32'h0000_0000

// ------------------------------------------------------------
// Operation codes and write forms
// ------------------------------------------------------------
`define CSR_OP_NONE         3'd0
`define CSR_OP_WRITE        3'd1
`define CSR_OP_ECALL        3'd2
`define CSR_OP_EBREAK       3'd3
`define CSR_OP_MRET         3'd4

`define CSR_RX_RW           2'd1
`define CSR_RX_RS           2'd2
`define CSR_RX_RC           2'd3

// Synchronous exception selects
`define CSR_EXCP_NONE           4'd0
`define CSR_EXCP_ILLEGAL_INSTR  4'd1
`define CSR_EXCP_INSTR_MISALIGN 4'd2
`define CSR_EXCP_STORE_MISALIGN 4'd3
`define CSR_EXCP_LOAD_MISALIGN  4'd4

// mcause codes
`define CSR_CAUSE_ILLEGAL_INSTR  32'd2
`define CSR_CAUSE_INSTR_MISALIGN 32'd0
`define CSR_CAUSE_STORE_MISALIGN 32'd6
`define CSR_CAUSE_LOAD_MISALIGN  32'd4
`define CSR_CAUSE_ECALL          32'd11
`define CSR_CAUSE_EBREAK         32'd3

`endif
